//--- hdl/chol_defines.svh
`ifndef CHOL_DEFINES_SVH
`define CHOL_DEFINES_SVH

// Matrix dimension, the engine factors an N by N matrix
`define CHOL_N 4

// Word width of one matrix element, signed two's complement
`define CHOL_DATA_W 32

// Fractional bits, so the default word is Q16.16
`define CHOL_FRAC_W 16

// Width of a row or column index, must cover CHOL_N-1
`define CHOL_IDX_W 2

`endif

//--- hdl/chol_pkg.sv
`include "chol_defines.svh"

package chol_pkg;

	typedef logic signed [`CHOL_DATA_W-1:0] fixed_t; // One matrix element in fixed point

	typedef logic [`CHOL_IDX_W-1:0] index_t; // Row or column number

	// Sequencer states, one pass over PIVOT, COL and UPDATE per column
	typedef enum logic [2:0] {
		IDLE,       // Loads pass through, waiting for start
		PIVOT_REQ,  // Check T_kk and fire the root unit
		PIVOT_WAIT, // Wait for the root, then write L_kk
		COL_REQ,    // Fire the divider for one element below the pivot
		COL_WAIT,   // Wait for the quotient, then write L_ik
		UPDATE,     // One multiply-subtract per cycle on the trailing triangle
		FINISH      // Raise done and settle pivot_err
	} chol_state_e;

endpackage

//--- hdl/chol_matrix_store.sv
`timescale 1ns/1ps
`include "chol_defines.svh"

module chol_matrix_store
	import chol_pkg::*;
(
	input  logic   i,
	input  logic   rst_n,
	input  logic   wr_en,   // Write lands at the next edge
	input  index_t wr_row,
	input  index_t wr_col,
	input  fixed_t wr_data,
	input  index_t a_row,
	input  index_t a_col,
	input  index_t b_row,
	input  index_t b_col,
	input  index_t r_row,
	input  index_t r_col,
	output fixed_t a_data,
	output fixed_t b_data,
	output fixed_t r_data
);

	localparam int N     = `CHOL_N;
	localparam int DEPTH = N * (N + 1) / 2; // Lower triangle only, row-major packing

	fixed_t mem [DEPTH];

	// Row r starts at r(r+1)/2 in the packed triangle
	function automatic int tri_idx(input index_t row, input index_t col);
		return (int'(row) * (int'(row) + 1)) / 2 + int'(col);
	endfunction

	// Upper elements are not stored and read as zero
	function automatic fixed_t tri_read(input index_t row, input index_t col);
		if (col > row)
			return '0;
		return mem[tri_idx(row, col)];
	endfunction

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			for (int e = 0; e < DEPTH; e++)
				mem[e] <= '0; // Factor reads as all zero after reset
		end else if (wr_en && (wr_col <= wr_row)) begin
			mem[tri_idx(wr_row, wr_col)] <= wr_data; // Upper writes are dropped
		end
	end

	assign a_data = tri_read(a_row, a_col); // Sequencer operand port
	assign b_data = tri_read(b_row, b_col); // Sequencer operand port
	assign r_data = tri_read(r_row, r_col); // External readback port

endmodule

//--- hdl/chol_sqrt.sv
`timescale 1ns/1ps
`include "chol_defines.svh"

module chol_sqrt
	import chol_pkg::*;
(
	input  logic   i,
	input  logic   rst_n,
	input  logic   start,    // One-cycle pulse, radicand sampled here
	input  fixed_t radicand, // Must be positive
	output fixed_t root,     // Held from done until the next start
	output logic   done
);

	localparam int W = `CHOL_DATA_W + `CHOL_FRAC_W; // Radicand widened by the fraction
	localparam int H = W / 2;                       // One root bit per cycle

	logic [W-1:0]           x;      // Radicand bits still to be consumed, two per step
	logic [H+1:0]           rem;    // Partial remainder
	logic [H-1:0]           q;      // Root bits found so far
	logic [$clog2(H+1)-1:0] cnt;    // Steps left, zero when idle
	logic [H+1:0]           rem_sh; // Remainder with the next two radicand bits
	logic [H+1:0]           trial;  // 4q+1, the test subtrahend
	logic                   ge;     // Next root bit
	logic [H+1:0]           rem_nx;
	logic [H-1:0]           q_nx;

	always_comb begin
		rem_sh = {rem[H-1:0], x[W-1 -: 2]};
		trial  = {q, 2'b01};
		ge     = (rem_sh >= trial);
		rem_nx = ge ? (rem_sh - trial) : rem_sh;
		q_nx   = {q[H-2:0], ge};
	end

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			if (start)
				cnt <= H[$clog2(H+1)-1:0];
			else if (cnt != '0)
				cnt <= cnt - 1'b1;
			done <= !start && (cnt == 1); // Last step, done lands H+1 cycles after start
		end
	end

	always_ff @(posedge i) begin
		if (start) begin
			x   <= {radicand, {`CHOL_FRAC_W{1'b0}}}; // Shift left by FRAC_W keeps Q format
			rem <= '0;
			q   <= '0;
		end else if (cnt != '0) begin
			x   <= {x[W-3:0], 2'b00};
			rem <= rem_nx;
			q   <= q_nx;
			if (cnt == 1)
				root <= {{(`CHOL_DATA_W - H){1'b0}}, q_nx}; // Floor of the root
		end
	end

endmodule

//--- hdl/chol_div.sv
`timescale 1ns/1ps
`include "chol_defines.svh"

module chol_div
	import chol_pkg::*;
(
	input  logic   i,
	input  logic   rst_n,
	input  logic   start,    // One-cycle pulse, operands sampled here
	input  fixed_t dividend,
	input  fixed_t divisor,  // Must be positive
	output fixed_t quotient, // Held from done until the next start
	output logic   done
);

	localparam int DW = `CHOL_DATA_W;
	localparam int W  = `CHOL_DATA_W + `CHOL_FRAC_W; // Numerator bits, one per cycle

	logic [DW-1:0]          mag;     // Magnitude of the dividend
	logic [W-1:0]           num;     // Numerator shifting out, quotient shifting in
	logic [DW:0]            rem;     // Partial remainder, one guard bit
	logic [DW-1:0]          dvsr;    // Divisor captured at start
	logic                   neg;     // Sign of the dividend, restored at the end
	logic [$clog2(W+1)-1:0] cnt;     // Steps left, zero when idle
	logic [DW:0]            rem_sh;
	logic                   ge;      // Next quotient bit
	logic [DW:0]            rem_nx;
	logic [W-1:0]           num_nx;
	logic [DW-1:0]          q_lo;    // Quotient cut to word width

	assign mag = dividend[DW-1] ? -dividend : dividend; // Most negative value maps to 2^(DW-1)

	always_comb begin
		rem_sh = {rem[DW-1:0], num[W-1]};
		ge     = (rem_sh >= {1'b0, dvsr});
		rem_nx = ge ? (rem_sh - {1'b0, dvsr}) : rem_sh; // Restore by keeping the old value
		num_nx = {num[W-2:0], ge};
		q_lo   = num_nx[DW-1:0];
	end

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			if (start)
				cnt <= W[$clog2(W+1)-1:0];
			else if (cnt != '0)
				cnt <= cnt - 1'b1;
			done <= !start && (cnt == 1); // Done lands W+1 cycles after start
		end
	end

	always_ff @(posedge i) begin
		if (start) begin
			num  <= {mag, {`CHOL_FRAC_W{1'b0}}}; // Pre-shift so the quotient keeps Q format
			rem  <= '0;
			dvsr <= divisor;
			neg  <= dividend[DW-1];
		end else if (cnt != '0) begin
			num <= num_nx;
			rem <= rem_nx;
			if (cnt == 1)
				quotient <= neg ? -q_lo : q_lo; // Truncates toward zero
		end
	end

endmodule

//--- hdl/chol_sequencer.sv
`timescale 1ns/1ps
`include "chol_defines.svh"

module chol_sequencer
	import chol_pkg::*;
(
	input  logic   i,
	input  logic   rst_n,
	input  logic   start,
	input  logic   load_en,     // Honoured only while idle
	input  index_t load_row,
	input  index_t load_col,
	input  fixed_t load_data,
	output logic   busy,
	output logic   done,
	output logic   pivot_err,
	output logic   wr_en,
	output index_t wr_row,
	output index_t wr_col,
	output fixed_t wr_data,
	output index_t a_row,
	output index_t a_col,
	output index_t b_row,
	output index_t b_col,
	input  fixed_t a_data,
	input  fixed_t b_data,
	output logic   sq_start,
	output fixed_t sq_radicand,
	input  fixed_t sq_root,
	input  logic   sq_done,
	output logic   dv_start,
	output fixed_t dv_dividend,
	output fixed_t dv_divisor,
	input  fixed_t dv_quotient,
	input  logic   dv_done
);

	localparam index_t LAST = index_t'(`CHOL_N - 1);

	chol_state_e                 state;
	index_t                      k;         // Current pivot column
	index_t                      row;       // Row being divided or updated
	index_t                      col;       // Column being updated, walks down to k+1
	index_t                      k_next;
	fixed_t                      lik;       // L_ik held for the rest of an update row
	fixed_t                      mul_a;
	logic signed [2*`CHOL_DATA_W-1:0] prod; // Full product before rescaling
	fixed_t                      upd;       // T_ij - L_ik*L_jk
	logic                        pivot_bad;

	assign k_next    = k + 1'b1;
	assign busy      = (state != IDLE);
	assign pivot_bad = (a_data <= fixed_t'(0)); // Port a sits on (k,k) in the pivot states
	assign mul_a     = (col == row) ? b_data : lik; // Diagonal step squares L_ik
	assign prod      = mul_a * b_data;
	assign upd       = a_data - fixed_t'(prod >>> `CHOL_FRAC_W); // Floor of the rescaled product

	// Unit operands come straight off the store ports, stable through the start cycle
	assign sq_radicand = a_data;
	assign dv_dividend = a_data;
	assign dv_divisor  = b_data;

	always_comb begin
		wr_en   = 1'b0;
		wr_row  = k;
		wr_col  = k;
		wr_data = upd;
		a_row   = k; // Pivot states and FINISH look at (k,k)
		a_col   = k;
		b_row   = k;
		b_col   = k;
		case (state)
			IDLE: begin
				wr_en   = load_en;
				wr_row  = load_row;
				wr_col  = load_col;
				wr_data = load_data;
			end
			PIVOT_WAIT: begin
				wr_en   = sq_done; // L_kk replaces T_kk
				wr_data = sq_root;
			end
			COL_REQ, COL_WAIT: begin
				a_row   = row; // T_ik over L_kk on port b
				wr_en   = (state == COL_WAIT) && dv_done;
				wr_row  = row;
				wr_data = dv_quotient;
			end
			UPDATE: begin
				a_row  = row; // T_ij in place
				a_col  = col;
				b_row  = col; // L_jk, which is L_ik on the diagonal step
				wr_en  = 1'b1;
				wr_row = row;
				wr_col = col;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			k         <= '0;
			row       <= '0;
			col       <= '0;
			done      <= 1'b0;
			pivot_err <= 1'b0;
			sq_start  <= 1'b0;
			dv_start  <= 1'b0;
		end else begin
			done     <= 1'b0;
			sq_start <= 1'b0;
			dv_start <= 1'b0;
			case (state)
				IDLE: if (start) begin
					pivot_err <= 1'b0; // Flag holds only until the next run
					k         <= '0;
					state     <= PIVOT_REQ;
				end
				PIVOT_REQ: if (pivot_bad) begin
					state <= FINISH; // Abort, T_kk stays in the store
				end else begin
					sq_start <= 1'b1;
					state    <= PIVOT_WAIT;
				end
				PIVOT_WAIT: if (sq_done) begin
					row   <= k_next;
					state <= (k == LAST) ? FINISH : COL_REQ; // Last column has nothing below
				end
				COL_REQ: begin
					dv_start <= 1'b1;
					state    <= COL_WAIT;
				end
				COL_WAIT: if (dv_done) begin
					if (row == LAST) begin
						row   <= k_next; // Update starts at the first trailing diagonal
						col   <= k_next;
						state <= UPDATE;
					end else begin
						row   <= row + 1'b1;
						state <= COL_REQ;
					end
				end
				UPDATE: if (col == k_next) begin
					if (row == LAST) begin
						k     <= k_next;
						state <= PIVOT_REQ;
					end else begin
						row <= row + 1'b1;
						col <= row + 1'b1; // Each row opens on its diagonal
					end
				end else begin
					col <= col - 1'b1;
				end
				FINISH: begin
					done      <= 1'b1;
					// (k,k) holds a positive root after a full run and the bad pivot after an abort
					pivot_err <= pivot_bad;
					state     <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i) begin
		if ((state == UPDATE) && (col == row))
			lik <= b_data; // Port b carries L_ik on the diagonal step
	end

endmodule

//--- hdl/chol_top.sv
`timescale 1ns/1ps

module chol_top
	import chol_pkg::*;
(
	input  logic   i,
	input  logic   rst_n,
	input  logic   start,     // One-cycle pulse while idle
	input  logic   load_en,
	input  index_t load_row,
	input  index_t load_col,
	input  fixed_t load_data,
	input  index_t rd_row,
	input  index_t rd_col,
	output fixed_t rd_data,   // Combinational, valid while busy is low
	output logic   busy,
	output logic   done,
	output logic   pivot_err
);

	logic   wr_en;
	index_t wr_row, wr_col;
	fixed_t wr_data;
	index_t a_row, a_col, b_row, b_col;
	fixed_t a_data, b_data;
	logic   sq_start, sq_done;
	fixed_t sq_radicand, sq_root;
	logic   dv_start, dv_done;
	fixed_t dv_dividend, dv_divisor, dv_quotient;

	// Sole writer of the store and sole user of the two units
	chol_sequencer u_seq (
		.i, .rst_n, .start,
		.load_en, .load_row, .load_col, .load_data,
		.busy, .done, .pivot_err,
		.wr_en, .wr_row, .wr_col, .wr_data,
		.a_row, .a_col, .b_row, .b_col, .a_data, .b_data,
		.sq_start, .sq_radicand, .sq_root, .sq_done,
		.dv_start, .dv_dividend, .dv_divisor, .dv_quotient, .dv_done
	);

	// Port r serves the external readback
	chol_matrix_store u_store (
		.i, .rst_n,
		.wr_en, .wr_row, .wr_col, .wr_data,
		.a_row, .a_col, .b_row, .b_col,
		.r_row (rd_row), .r_col (rd_col),
		.a_data, .b_data, .r_data (rd_data)
	);

	chol_sqrt u_sqrt (.i, .rst_n, .start (sq_start), .radicand (sq_radicand),
		.root (sq_root), .done (sq_done));

	chol_div u_div (.i, .rst_n, .start (dv_start), .dividend (dv_dividend),
		.divisor (dv_divisor), .quotient (dv_quotient), .done (dv_done));

endmodule

//--- dv/chol_tb_clk.sv
`timescale 1ns/1ps

module chol_tb_clk #(
	parameter int PERIOD_NS = 40 // Full clock period
) (
	output logic i
);

	initial i = 1'b0; // Low at time zero, first rising edge half a period in

	always #(PERIOD_NS / 2) i = ~i; // Free running for the whole simulation

endmodule

//--- dv/chol_assert.sv
`timescale 1ns/1ps

module chol_assert (
	input logic i,
	input logic rst_n,
	input logic start,
	input logic busy,
	input logic done,
	input logic pivot_err
);

	int fail_cnt = 0; // Assertion failures seen so far, read by the testbench at the end

	// The done strobe never stretches past a single cycle
	a_done_one_cycle: assert property (@(posedge i) disable iff (!rst_n)
		done |=> !done) else begin
		fail_cnt++;
		$error("done stayed high for more than one cycle");
	end

	// busy falls in the same cycle that done pulses
	a_done_not_busy: assert property (@(posedge i) disable iff (!rst_n)
		done |-> !busy) else begin
		fail_cnt++;
		$error("busy still high while done pulses");
	end

	// The error flag can only be raised by a finishing run
	a_err_with_done: assert property (@(posedge i) disable iff (!rst_n)
		$rose(pivot_err) |-> done) else begin
		fail_cnt++;
		$error("pivot_err rose without done");
	end

	// An idle engine accepts start on the next edge
	a_start_busy: assert property (@(posedge i) disable iff (!rst_n)
		(start && !busy) |=> busy) else begin
		fail_cnt++;
		$error("start while idle did not raise busy");
	end

endmodule

bind chol_top chol_assert u_assert (.*); // Watches the top-level control ports

//--- dv/chol_tb.sv
`timescale 1ns/1ps
`include "chol_defines.svh"

module chol_tb
	import chol_pkg::*;
();

	localparam int N         = `CHOL_N;
	localparam int FRAC      = `CHOL_FRAC_W;
	localparam int NUM_TESTS = 23;                  // Diagonal, twenty random, abort, garbage loads
	localparam int RUN_LIMIT = N * (N * 60 + 60);   // Cycles one run may take before done
	localparam longint WATCHDOG_NS = longint'(NUM_TESTS + 1) * RUN_LIMIT * 40;

	typedef fixed_t mat_t [N][N]; // Row-major with the upper half kept at zero

	logic   i;
	logic   rst_n;
	logic   start;
	logic   load_en;
	index_t load_row;
	index_t load_col;
	fixed_t load_data;
	index_t rd_row;
	index_t rd_col;
	fixed_t rd_data;
	logic   busy;
	logic   done;
	logic   pivot_err;

	integer seed;
	int     val_errs   = 0; // Wrong rd_data or pivot_err values
	int     proto_errs = 0; // Missing done and other failures
	int     sva_errs;       // Failures of the bound assertions
	mat_t   exp_l;          // Expected store contents after the run
	bit     exp_err;
	event   check_req;
	event   check_ack;

	chol_tb_clk #(.PERIOD_NS(40)) u_clk (.i);

	chol_top i_dut (.*);

	// Largest r with r*r <= x found one result bit at a time from the top
	function automatic longint floor_sqrt(input longint x);
		longint r;
		longint t;
		r = 0;
		for (int b = 31; b >= 0; b--) begin
			t = r | (longint'(1) << b);
			if (t * t <= x)
				r = t;
		end
		return r;
	endfunction

	// Right-looking factorisation in the engine's fixed point that returns the pivot flag
	function automatic bit cholesky_ref(input mat_t a, output mat_t l);
		longint prod;
		bit     err;
		l   = a;
		err = 1'b0;
		for (int k = 0; k < N; k++) begin
			if (!err) begin
				if (l[k][k] <= 0) begin
					err = 1'b1; // Abort leaves the bad pivot and the trailing part as they are
				end else begin
					l[k][k] = fixed_t'(floor_sqrt(longint'(l[k][k]) <<< FRAC));
					for (int r = k + 1; r < N; r++)
						l[r][k] = fixed_t'((longint'(l[r][k]) <<< FRAC) / longint'(l[k][k]));
					for (int r = k + 1; r < N; r++) begin
						for (int c = k + 1; c <= r; c++) begin
							prod    = longint'(l[r][k]) * longint'(l[c][k]);
							l[r][c] = l[r][c] - fixed_t'(prod >>> FRAC); // Floor on the rescale
						end
					end
				end
			end
		end
		return err;
	endfunction

	// B times B transposed plus 4.0 on the diagonal with B entries in [-2, 2)
	task automatic make_spd_matrix(output mat_t m);
		mat_t   b;
		integer rnd;
		longint acc;
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				rnd     = $random(seed);
				b[r][c] = $signed(rnd[FRAC+1:0]); // 18 signed bits span two integer bits
			end
		end
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				acc = 0;
				for (int t = 0; t < N && c <= r; t++)
					acc += (longint'(b[r][t]) * longint'(b[c][t])) >>> FRAC;
				m[r][c] = (c > r) ? fixed_t'(0) : fixed_t'(acc);
				if (r == c)
					m[r][c] = m[r][c] + fixed_t'(32'h0004_0000);
			end
		end
	endtask

	task automatic check_low(input string name, input logic got);
		if (got !== 1'b0) begin
			$display("Fail %s after reset: expected %h, got %h", name, 1'b0, got);
			val_errs++;
		end
	endtask

	task automatic load_matrix(input mat_t m);
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c <= r; c++) begin
				@(negedge i);
				load_en   = 1'b1;
				load_row  = index_t'(r);
				load_col  = index_t'(c);
				load_data = m[r][c];
			end
		end
		@(negedge i);
		load_en = 1'b0;
	endtask

	// Loads, starts, waits for done and hands the readback to the compare process
	task automatic factor_and_check(input mat_t m, input bit garbage);
		int cyc;
		load_matrix(m);
		exp_err = cholesky_ref(m, exp_l);
		start   = 1'b1;
		@(negedge i);
		start = 1'b0;
		cyc   = 0;
		while (done !== 1'b1 && cyc < RUN_LIMIT) begin
			if (garbage) begin
				load_en   = 1'b1; // Must be ignored while busy
				load_row  = index_t'($random(seed));
				load_col  = index_t'($random(seed));
				load_data = $random(seed);
			end
			@(negedge i);
			cyc++;
		end
		load_en = 1'b0; // Dropped before the first idle edge
		if (done !== 1'b1) begin
			$display("No done pulse within %0d cycles of start", RUN_LIMIT);
			proto_errs++;
		end else begin
			-> check_req;
			@(check_ack);
		end
	endtask

	// Reads the whole matrix including the upper half and compares with exp_l
	always begin
		fixed_t want;
		@(check_req);
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				@(negedge i);
				rd_row = index_t'(r);
				rd_col = index_t'(c);
				@(posedge i);
				want = (c <= r) ? exp_l[r][c] : fixed_t'(0);
				if (rd_data !== want) begin
					$display("Fail rd_data (%0d,%0d): expected %h, got %h", r, c, want, rd_data);
					val_errs++;
				end
			end
		end
		if (pivot_err !== exp_err) begin
			$display("Fail pivot_err: expected %h, got %h", exp_err, pivot_err);
			val_errs++;
		end
		-> check_ack;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Run stopped by the watchdog after %0d ns", WATCHDOG_NS);
		$display("Test failures found");
		$finish;
	end

	initial begin
		mat_t m;
		seed      = 32'h9e548811;
		rst_n     = 1'b0;
		start     = 1'b0;
		load_en   = 1'b0;
		load_row  = '0;
		load_col  = '0;
		load_data = '0;
		rd_row    = '0;
		rd_col    = '0;
		repeat (16) @(negedge i);
		rst_n = 1'b1;
		@(negedge i);
		check_low("busy", busy);
		check_low("done", done);
		check_low("pivot_err", pivot_err);
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++)
				exp_l[r][c] = '0; // Store clears on reset
		end
		exp_err = 1'b0;
		-> check_req;
		@(check_ack);
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++)
				m[r][c] = '0;
		end
		m[0][0] = 32'h0002_0000; // 2.0, 3.0, 0.5 and 10.0 all take rounded-down roots
		m[1][1] = 32'h0003_0000;
		m[2][2] = 32'h0000_8000;
		m[3][3] = 32'h000a_0000;
		factor_and_check(m, 1'b0);
		for (int t = 0; t < 20; t++) begin
			make_spd_matrix(m);
			factor_and_check(m, 1'b0);
		end
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++)
				m[r][c] = (r == c) ? fixed_t'(32'h0001_0000) : fixed_t'(0);
		end
		m[2][0] = 32'h0002_0000; // T_22 falls to 1 - 4 after the first update
		factor_and_check(m, 1'b0);
		make_spd_matrix(m);
		factor_and_check(m, 1'b1);
		sva_errs = i_dut.u_assert.fail_cnt;
		$display("Checks finished with %0d value errors, %0d other errors, %0d assertion errors",
			val_errs, proto_errs, sva_errs);
		if (val_errs + proto_errs + sva_errs == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- sources.f
+incdir+hdl
hdl/chol_pkg.sv
hdl/chol_matrix_store.sv
hdl/chol_sqrt.sv
hdl/chol_div.sv
hdl/chol_sequencer.sv
hdl/chol_top.sv
dv/chol_tb_clk.sv
dv/chol_assert.sv
dv/chol_tb.sv

//--- Bender.yml
package:
  name: chol

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/chol_pkg.sv
      - hdl/chol_matrix_store.sv
      - hdl/chol_sqrt.sv
      - hdl/chol_div.sv
      - hdl/chol_sequencer.sv
      - hdl/chol_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/chol_tb_clk.sv
      - dv/chol_assert.sv
      - dv/chol_tb.sv
